//--- src/exu_pkg.sv
// shared width, ALU operation encoding and stage record types for the execute/memory slice
package exu_pkg;

	// data and address width
	localparam int XLEN = 32;

	// number of byte lanes in one data word
	localparam int LANES = XLEN / 8;

	////////////////////////////////////////////////////////////
	// ALU operations, one-hot, bit index per operation

	localparam int ALU_OP_W = 12;

	localparam int OP_ADD  = 0;
	localparam int OP_SUB  = 1;
	localparam int OP_SLT  = 2;
	localparam int OP_SLTU = 3;
	localparam int OP_AND  = 4;
	localparam int OP_OR   = 5;
	localparam int OP_NOR  = 6;
	localparam int OP_XOR  = 7;
	localparam int OP_SLL  = 8;
	localparam int OP_SRL  = 9;
	localparam int OP_SRA  = 10;
	localparam int OP_LUI  = 11;

	typedef logic [ALU_OP_W-1:0] alu_op_t;

	////////////////////////////////////////////////////////////
	// stage records

	// decoded instruction entering execute
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] alu_src1;
		logic [XLEN-1:0] alu_src2;
		alu_op_t         alu_op;
		logic [XLEN-1:0] store_data;
		logic [4:0]      rf_waddr;
		logic            mem_en;
		logic            mem_we;
		logic            mem_byte;
		logic            rf_we;
		logic            rf_from_mem;
	} id_to_exe_t;

	// execute result handed to the memory stage
	typedef struct packed {
		logic [XLEN-1:0]  pc;
		logic [XLEN-1:0]  alu_result;
		logic [4:0]       rf_waddr;
		logic [LANES-1:0] byte_en;
		logic             mem_byte;
		logic             rf_we;
		logic             rf_from_mem;
	} exe_to_mem_t;

	// writeback record presented to the register file side
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic            rf_we;
		logic [4:0]      rf_waddr;
		logic [XLEN-1:0] rf_wdata;
	} wb_t;

	// data RAM request, we is one bit per byte lane
	typedef struct packed {
		logic             en;
		logic [LANES-1:0] we;
		logic [XLEN-1:0]  addr;
		logic [XLEN-1:0]  wdata;
	} ram_req_t;

endpackage

//--- src/alu.sv
// combinational 32-bit ALU, one-hot operation select, used inside the execute stage
`timescale 1ns/100ps

module alu import exu_pkg::*;
(
	input  alu_op_t         op,
	input  logic [XLEN-1:0] src1,
	input  logic [XLEN-1:0] src2,
	output logic [XLEN-1:0] result
);

	logic [XLEN-1:0] add_res;
	logic [XLEN-1:0] sub_res;
	logic [XLEN-1:0] slt_res;
	logic [XLEN-1:0] sltu_res;
	logic [XLEN-1:0] and_res;
	logic [XLEN-1:0] or_res;
	logic [XLEN-1:0] nor_res;
	logic [XLEN-1:0] xor_res;
	logic [XLEN-1:0] sll_res;
	logic [XLEN-1:0] srl_res;
	logic [XLEN-1:0] sra_res;
	logic [XLEN-1:0] lui_res;
	logic [4:0]      shamt;

	// shift amount from the low five bits only
	assign shamt = src2[4:0];

	////////////////////////////////////////////////////////////
	// every operation computed in parallel

	assign add_res  = src1 + src2;
	assign sub_res  = src1 - src2;
	assign slt_res  = {{(XLEN-1){1'b0}}, ($signed(src1) < $signed(src2))};
	assign sltu_res = {{(XLEN-1){1'b0}}, (src1 < src2)};
	assign and_res  = src1 & src2;
	assign or_res   = src1 | src2;
	assign nor_res  = ~(src1 | src2);
	assign xor_res  = src1 ^ src2;
	assign sll_res  = src1 << shamt;
	assign srl_res  = src1 >> shamt;
	assign sra_res  = $unsigned($signed(src1) >>> shamt);
	// upper immediate already placed by the decoder
	assign lui_res  = src2;

	////////////////////////////////////////////////////////////
	// and-or select, op is one-hot

	always_comb
	begin
		result = '0;
		result |= {XLEN{op[OP_ADD]}}  & add_res;
		result |= {XLEN{op[OP_SUB]}}  & sub_res;
		result |= {XLEN{op[OP_SLT]}}  & slt_res;
		result |= {XLEN{op[OP_SLTU]}} & sltu_res;
		result |= {XLEN{op[OP_AND]}}  & and_res;
		result |= {XLEN{op[OP_OR]}}   & or_res;
		result |= {XLEN{op[OP_NOR]}}  & nor_res;
		result |= {XLEN{op[OP_XOR]}}  & xor_res;
		result |= {XLEN{op[OP_SLL]}}  & sll_res;
		result |= {XLEN{op[OP_SRL]}}  & srl_res;
		result |= {XLEN{op[OP_SRA]}}  & sra_res;
		result |= {XLEN{op[OP_LUI]}}  & lui_res;
	end

endmodule

//--- src/exe_stage.sv
// execute stage between decode and memory, runs the ALU on the held record and issues RAM requests
`timescale 1ns/100ps

module exe_stage import exu_pkg::*;
(
	input  logic        clk,
	input  logic        reset,

	// from decode
	input  logic        in_valid,
	input  id_to_exe_t  in_rec,
	output logic        in_allow_in,

	// to memory stage
	output logic        out_valid,
	output exe_to_mem_t out_rec,
	input  logic        out_allow_in,

	// data RAM
	output ram_req_t    ram_req
);

	logic             exe_valid;
	id_to_exe_t       exe_rec;
	logic             out_xfer;
	logic [XLEN-1:0]  alu_result;
	logic [LANES-1:0] lane_en;
	logic [XLEN-1:0]  store_word;

	////////////////////////////////////////////////////////////
	// pipeline control

	// every operation finishes in one cycle
	assign in_allow_in = ~exe_valid | out_allow_in;
	assign out_valid   = exe_valid;
	assign out_xfer    = out_valid & out_allow_in;

	always_ff @(posedge clk)
	begin
		if (reset)
			exe_valid <= 1'b0;
		else if (in_allow_in)
			exe_valid <= in_valid;
	end

	// payload only loads on an accepted transfer
	always_ff @(posedge clk)
	begin
		if (in_valid && in_allow_in)
			exe_rec <= in_rec;
	end

	////////////////////////////////////////////////////////////
	// ALU

	alu alu_inst (
		.op     (exe_rec.alu_op),
		.src1   (exe_rec.alu_src1),
		.src2   (exe_rec.alu_src2),
		.result (alu_result)
	);

	////////////////////////////////////////////////////////////
	// data RAM request

	// byte access picks one lane from address bits 1:0
	always_comb
	begin
		if (exe_rec.mem_byte)
		begin
			case (alu_result[1:0])
				2'b00:   lane_en = 4'b0001;
				2'b01:   lane_en = 4'b0010;
				2'b10:   lane_en = 4'b0100;
				default: lane_en = 4'b1000;
			endcase
		end
		else
		begin
			lane_en = 4'b1111;
		end
	end

	// byte stores replicate the low byte across the word
	assign store_word = exe_rec.mem_byte ? {LANES{exe_rec.store_data[7:0]}}
	                                     : exe_rec.store_data;

	// only fire when the record actually moves on
	assign ram_req.en    = exe_rec.mem_en & out_xfer;
	assign ram_req.we    = (exe_rec.mem_en & exe_rec.mem_we & out_xfer) ? lane_en : '0;
	assign ram_req.addr  = alu_result;
	assign ram_req.wdata = store_word;

	////////////////////////////////////////////////////////////
	// record to memory stage

	assign out_rec.pc          = exe_rec.pc;
	assign out_rec.alu_result  = alu_result;
	assign out_rec.rf_waddr    = exe_rec.rf_waddr;
	assign out_rec.byte_en     = lane_en;
	assign out_rec.mem_byte    = exe_rec.mem_byte;
	assign out_rec.rf_we       = exe_rec.rf_we;
	assign out_rec.rf_from_mem = exe_rec.rf_from_mem;

endmodule

//--- src/data_ram.sv
// word-wide data RAM with byte-lane writes and a registered read, driven by the execute stage request
`timescale 1ns/100ps

module data_ram import exu_pkg::*;
#(
	parameter int DEPTH_WORDS = 256
)
(
	input  logic            clk,
	input  ram_req_t        req,
	output logic [XLEN-1:0] rdata
);

	localparam int IDX_W = $clog2(DEPTH_WORDS);

	logic [XLEN-1:0]  mem [DEPTH_WORDS];
	logic [IDX_W-1:0] word_idx;

	// word address, byte offset dropped
	assign word_idx = req.addr[IDX_W+1:2];

	////////////////////////////////////////////////////////////
	// lane writes

	always_ff @(posedge clk)
	begin
		if (req.en)
		begin
			for (int lane = 0; lane < LANES; lane++)
			begin
				if (req.we[lane])
					mem[word_idx][lane*8 +: 8] <= req.wdata[lane*8 +: 8];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// read port

	// holds the last read word until the next enabled read
	always_ff @(posedge clk)
	begin
		if (req.en && (req.we == '0))
			rdata <= mem[word_idx];
	end

endmodule

//--- src/mem_stage.sv
// memory pipeline stage: holds one record, shapes load data and forms the writeback record
`timescale 1ns/100ps

module mem_stage import exu_pkg::*;
(
	input  logic            clk,
	input  logic            reset,

	// from execute
	input  logic            in_valid,
	input  exe_to_mem_t     in_rec,
	output logic            in_allow_in,

	// read data from the data RAM
	input  logic [XLEN-1:0] ram_rdata,

	// writeback side
	output logic            wb_valid,
	output wb_t             wb_rec,
	input  logic            wb_allow_in
);

	logic            mem_valid;
	exe_to_mem_t     mem_rec;
	logic [7:0]      load_byte;
	logic [XLEN-1:0] load_value;

	////////////////////////////////////////////////////////////
	// pipeline control

	assign in_allow_in = ~mem_valid | wb_allow_in;
	assign wb_valid    = mem_valid;

	always_ff @(posedge clk)
	begin
		if (reset)
			mem_valid <= 1'b0;
		else if (in_allow_in)
			mem_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid && in_allow_in)
			mem_rec <= in_rec;
	end

	////////////////////////////////////////////////////////////
	// load data

	// byte_en is one-hot from address bits 1:0 on byte accesses
	always_comb
	begin
		load_byte = '0;
		for (int lane = 0; lane < LANES; lane++)
		begin
			load_byte |= {8{mem_rec.byte_en[lane]}} & ram_rdata[lane*8 +: 8];
		end
	end

	// sign extend byte loads, words pass through
	assign load_value = mem_rec.mem_byte ? {{(XLEN-8){load_byte[7]}}, load_byte}
	                                     : ram_rdata;

	////////////////////////////////////////////////////////////
	// writeback record

	assign wb_rec.pc       = mem_rec.pc;
	assign wb_rec.rf_we    = mem_rec.rf_we;
	assign wb_rec.rf_waddr = mem_rec.rf_waddr;
	assign wb_rec.rf_wdata = mem_rec.rf_from_mem ? load_value : mem_rec.alu_result;

endmodule

//--- src/exu_top.sv
// top level of the execute/memory slice, connects execute stage, data RAM and memory stage
`timescale 1ns/100ps

module exu_top import exu_pkg::*;
#(
	parameter int DEPTH_WORDS = 256
)
(
	input  logic       clk,
	input  logic       reset,

	// decoded instructions in
	input  logic       in_valid,
	input  id_to_exe_t in_rec,
	output logic       in_allow_in,

	// writeback out
	output logic       wb_valid,
	output wb_t        wb_rec,
	input  logic       wb_allow_in
);

	logic            exe_to_mem_valid;
	exe_to_mem_t     exe_to_mem_rec;
	logic            mem_allow_in;
	ram_req_t        ram_req;
	logic [XLEN-1:0] ram_rdata;

	exe_stage exe_stage_inst (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_rec       (in_rec),
		.in_allow_in  (in_allow_in),
		.out_valid    (exe_to_mem_valid),
		.out_rec      (exe_to_mem_rec),
		.out_allow_in (mem_allow_in),
		.ram_req      (ram_req)
	);

	data_ram #(
		.DEPTH_WORDS (DEPTH_WORDS)
	) data_ram_inst (
		.clk   (clk),
		.req   (ram_req),
		.rdata (ram_rdata)
	);

	mem_stage mem_stage_inst (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (exe_to_mem_valid),
		.in_rec      (exe_to_mem_rec),
		.in_allow_in (mem_allow_in),
		.ram_rdata   (ram_rdata),
		.wb_valid    (wb_valid),
		.wb_rec      (wb_rec),
		.wb_allow_in (wb_allow_in)
	);

endmodule

//--- verif/exu_tb.sv
// self-checking testbench for exu_top, replays records from the stimulus file under random stalls
`timescale 1ns/100ps

module exu_tb import exu_pkg::*;
();

	localparam int MAX_TESTS = 64;

	logic       clk = 1'b0;
	logic       reset = 1'b1;
	logic       in_valid = 1'b0;
	id_to_exe_t in_rec = '0;
	logic       in_allow_in;
	logic       wb_valid;
	wb_t        wb_rec;
	logic       wb_allow_in = 1'b0;

	string      test_name [MAX_TESTS];
	id_to_exe_t stim_rec [MAX_TESTS];
	wb_t        exp_rec [MAX_TESTS];
	int         num_tests = 0;

	int          cycle = 0;
	int          timeout_limit = 0;
	int          drive_idx = 0;
	int          rx_count = 0;
	int          pass_count = 0;
	int          fail_count = 0;
	int          first_accept_cycle = -1;
	logic        seen_valid = 1'b0;
	logic        random_on = 1'b0;
	logic        insert_gap = 1'b0;
	logic [31:0] lfsr = 32'h5bc3_c41c;

	exu_top #(
		.DEPTH_WORDS (256)
	) exu_top_inst (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_rec      (in_rec),
		.in_allow_in (in_allow_in),
		.wb_valid    (wb_valid),
		.wb_rec      (wb_rec),
		.wb_allow_in (wb_allow_in)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	////////////////////////////////////////////////////////////
	// helpers

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic fb;
		fb = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], fb};
	endfunction

	function automatic string wb_text(input wb_t rec);
		return $sformatf("{pc %h we %b rd %0d data %h}", rec.pc, rec.rf_we, rec.rf_waddr,
			rec.rf_wdata);
	endfunction

	task automatic check_wb(input string name, input wb_t expected, input wb_t actual);
		if (actual !== expected)
		begin
			$display("Mismatch %s: expected %s actual %s", name, wb_text(expected),
				wb_text(actual));
			fail_count++;
		end
		else
		begin
			$display("ok      %s", name);
			pass_count++;
		end
	endtask

	task automatic check_count(input int expected, input int actual);
		if (actual != expected)
		begin
			$display("Mismatch record_count: expected %0d actual %0d", expected, actual);
			fail_count++;
		end
	endtask

	task automatic check_latency(input int expected, input int actual);
		if (actual != expected)
		begin
			$display("Mismatch first_latency: expected %0d actual %0d", expected, actual);
			fail_count++;
		end
	endtask

	// one record per non-comment line, all fields hex after the name
	task automatic load_stimulus();
		int          fd;
		int          n;
		string       line;
		string       name;
		logic [31:0] fld [15];
		id_to_exe_t  rec;
		wb_t         exp_wb;
		fd = $fopen("verif/exu_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file verif/exu_stimulus.txt");
			fail_count++;
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
					fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
					fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14]);
				if (n != 16 || num_tests >= MAX_TESTS)
				begin
					$display("stimulus line could not be used: %s", line);
					fail_count++;
				end
				else
				begin
					rec.pc          = fld[0];
					rec.alu_src1    = fld[1];
					rec.alu_src2    = fld[2];
					rec.alu_op      = fld[3][11:0];
					rec.store_data  = fld[4];
					rec.rf_waddr    = fld[5][4:0];
					rec.mem_en      = fld[6][0];
					rec.mem_we      = fld[7][0];
					rec.mem_byte    = fld[8][0];
					rec.rf_we       = fld[9][0];
					rec.rf_from_mem = fld[10][0];
					exp_wb.pc       = fld[11];
					exp_wb.rf_we    = fld[12][0];
					exp_wb.rf_waddr = fld[13][4:0];
					exp_wb.rf_wdata = fld[14];
					test_name[num_tests] = name;
					stim_rec[num_tests]  = rec;
					exp_rec[num_tests]   = exp_wb;
					num_tests++;
				end
			end
			$fclose(fd);
		end
		if (num_tests == 0)
		begin
			$display("no tests were read from the stimulus file");
			fail_count++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// driver and back-pressure, the only user of the LFSR

	always @(posedge clk)
	begin
		if (reset)
		begin
			in_valid    <= 1'b0;
			wb_allow_in <= 1'b0;
		end
		else
		begin
			// first two records go in back to back with the sink ready
			random_on = (drive_idx >= 2);
			if (random_on)
			begin
				lfsr = lfsr_next(lfsr);
				wb_allow_in <= lfsr[0];
			end
			else
				wb_allow_in <= 1'b1;
			if (in_valid && in_allow_in)
			begin
				if (drive_idx == 0)
					first_accept_cycle = cycle;
				drive_idx++;
			end
			if (!in_valid || in_allow_in)
			begin
				insert_gap = 1'b0;
				if (random_on)
				begin
					lfsr = lfsr_next(lfsr);
					insert_gap = lfsr[0];
				end
				if (drive_idx < num_tests && !insert_gap)
				begin
					in_valid <= 1'b1;
					in_rec   <= stim_rec[drive_idx];
				end
				else
					in_valid <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// writeback monitor

	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (wb_valid && !seen_valid)
			begin
				seen_valid = 1'b1;
				if (first_accept_cycle < 0)
				begin
					$display("wb_valid went high before any record was accepted");
					fail_count++;
				end
				else
					check_latency(2, cycle - first_accept_cycle);
			end
			if (wb_valid && wb_allow_in)
			begin
				if (rx_count < num_tests)
					check_wb(test_name[rx_count], exp_rec[rx_count], wb_rec);
				else
				begin
					$display("extra writeback record after the last test, pc %h", wb_rec.pc);
					fail_count++;
				end
				rx_count++;
			end
		end
	end

	initial
	begin
		load_stimulus();
		timeout_limit = 8 * num_tests + 100;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		while (rx_count < num_tests && cycle < timeout_limit)
			@(negedge clk);
		if (rx_count < num_tests)
		begin
			$display("run timed out after %0d cycles with %0d of %0d records written back",
				cycle, rx_count, num_tests);
			fail_count++;
		end
		else
			repeat (20) @(negedge clk);
		check_count(num_tests, rx_count);
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- verif/exu_stimulus.txt
# name pc src1 src2 alu_op store_data rf_waddr mem_en mem_we mem_byte rf_we rf_from_mem
# then expected writeback: pc rf_we rf_waddr rf_wdata, every field after the name in hex
add        00001000 00000005 00000007 001 00000000 01 0 0 0 1 0 00001000 1 01 0000000c
sub        00001004 00000003 00000005 002 00000000 02 0 0 0 1 0 00001004 1 02 fffffffe
slt_neg    00001008 ffffffff 00000001 004 00000000 03 0 0 0 1 0 00001008 1 03 00000001
slt_pos    0000100c 00000005 fffffffd 004 00000000 04 0 0 0 1 0 0000100c 1 04 00000000
sltu_big   00001010 ffffffff 00000001 008 00000000 05 0 0 0 1 0 00001010 1 05 00000000
sltu_small 00001014 00000001 ffffffff 008 00000000 06 0 0 0 1 0 00001014 1 06 00000001
and        00001018 f0f0f0f0 0ff00ff0 010 00000000 07 0 0 0 1 0 00001018 1 07 00f000f0
or         0000101c f0f0f0f0 0ff00ff0 020 00000000 08 0 0 0 1 0 0000101c 1 08 fff0fff0
nor        00001020 12340000 00005678 040 00000000 09 0 0 0 1 0 00001020 1 09 edcba987
xor        00001024 aaaa5555 ffff0000 080 00000000 0a 0 0 0 1 0 00001024 1 0a 55555555
sll        00001028 00000003 00000024 100 00000000 0b 0 0 0 1 0 00001028 1 0b 00000030
srl        0000102c 80000000 00000004 200 00000000 0c 0 0 0 1 0 0000102c 1 0c 08000000
sra        00001030 80000000 00000004 400 00000000 0d 0 0 0 1 0 00001030 1 0d f8000000
lui        00001034 deadbeef 12340000 800 00000000 0e 0 0 0 1 0 00001034 1 0e 12340000
add_nowe   00001038 00000010 00000020 001 00000000 0f 0 0 0 0 0 00001038 0 0f 00000030
sw_word    0000103c 00000040 00000000 001 11223344 00 1 1 0 0 0 0000103c 0 00 00000040
lw_word    00001040 00000040 00000000 001 00000000 10 1 0 0 1 1 00001040 1 10 11223344
sw_fill    00001044 00000080 00000000 001 a5a5a5a5 00 1 1 0 0 0 00001044 0 00 00000080
sb_lane0   00001048 00000080 00000000 001 deadbe01 00 1 1 1 0 0 00001048 0 00 00000080
lw_lane0   0000104c 00000080 00000000 001 00000000 11 1 0 0 1 1 0000104c 1 11 a5a5a501
sb_lane1   00001050 00000080 00000001 001 deadbe82 00 1 1 1 0 0 00001050 0 00 00000081
lw_lane1   00001054 00000080 00000000 001 00000000 12 1 0 0 1 1 00001054 1 12 a5a58201
sb_lane2   00001058 00000080 00000002 001 deadbe03 00 1 1 1 0 0 00001058 0 00 00000082
sb_lane3   0000105c 00000080 00000003 001 deadbef4 00 1 1 1 0 0 0000105c 0 00 00000083
lw_all     00001060 00000080 00000000 001 00000000 13 1 0 0 1 1 00001060 1 13 f4038201
lb_lane0   00001064 00000080 00000000 001 00000000 14 1 0 1 1 1 00001064 1 14 00000001
lb_lane1   00001068 00000080 00000001 001 00000000 15 1 0 1 1 1 00001068 1 15 ffffff82
lb_lane2   0000106c 00000080 00000002 001 00000000 16 1 0 1 1 1 0000106c 1 16 00000003
lb_lane3   00001070 00000080 00000003 001 00000000 17 1 0 1 1 1 00001070 1 17 fffffff4

//--- build.f
src/exu_pkg.sv
src/alu.sv
src/exe_stage.sv
src/data_ram.sv
src/mem_stage.sv
src/exu_top.sv
verif/exu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= exu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
